//--- pe_accel_top.f
+incdir+verilog
+incdir+verification
verilog/pe_pkg.sv
verilog/mac_pe.sv
verilog/pe_array.sv
verilog/piso.sv
verilog/pe_accel_top.sv
verification/tb_pe_accel_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the MAC row and serializer testbench with Verilator.
# The exit status is that of the simulation: zero on pass, nonzero on
# any $fatal raised by the testbench.

set -e

# Work from the project root so the file list paths resolve
cd "$(dirname "$0")"

# Compile the testbench and RTL into one binary
verilator --binary --timing \
    --top-module tb_pe_accel_top \
    -f pe_accel_top.f \
    -o sim_pe_accel

# Run it
./obj_dir/sim_pe_accel

//--- verification/tb_pe_accel_tasks.svh
`ifndef TB_PE_ACCEL_TASKS_SVH
`define TB_PE_ACCEL_TASKS_SVH

//////////////////////////////////////////////////
// Helpers
//////////////////////////////////////////////////

// xorshift32 step
function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    end
endtask

// Outputs seen during the cycle that ends now
task automatic collect_outputs();
    acc_t want;
    if (overrun) begin
        overrun_cnt = overrun_cnt + 1;
    end
    if (s_valid) begin
        if (!fetch) begin
            fail_run("s_valid was high in a cycle that followed no fetch");
        end else if (exp_q.size() == 0) begin
            fail_run("s_valid carried a word that no finished sum accounts for");
        end else begin
            want = exp_q.pop_front();
            check_value("s_out", s_out, want);
            // Words still waiting keep the serializer busy
            if (exp_q.size() != 0) begin
                check_value("busy", 32'(busy), 32'h1);
            end
        end
    end
endtask

// One clock cycle of stimulus
// Model follows the activation
task automatic tick(input logic f, input logic av, input data_t a, input logic al);
    int i;
    @(negedge clk);
    collect_outputs();
    w_wr      = 1'b0;
    fetch     = f;
    act       = a;
    act_valid = av;
    act_last  = al;
    if (av) begin
        for (i = 0; i < `PE_NUM; i++) begin
            // Wrapping signed sum of activation times weight
            run_m[i] = run_m[i] + acc_t'(int'(weight_m[i]) * int'(a));
            if (al) begin
                done_m[i] = run_m[i];
                run_m[i]  = '0;
            end
        end
    end
endtask

task automatic write_weight(input int idx, input data_t val);
    @(negedge clk);
    collect_outputs();
    fetch       = 1'b0;
    act_valid   = 1'b0;
    act_last    = 1'b0;
    w_wr        = 1'b1;
    w_addr      = AW'(idx);
    w_data      = val;
    weight_m[idx] = val;
endtask

task automatic load_random_weights();
    int i;
    for (i = 0; i < `PE_NUM; i++) begin
        write_weight(i, data_t'(next_rand()));
    end
endtask

// Random activations with act_last on the final one
task automatic stream_run(input int len, input logic with_fetch);
    int    k;
    data_t a;
    act_log.delete();
    for (k = 0; k < len; k++) begin
        a = data_t'(next_rand());
        act_log.push_back(a);
        tick(with_fetch, 1'b1, a, k == len - 1);
    end
endtask

task automatic replay_run();
    int k;
    for (k = 0; k < act_log.size(); k++) begin
        tick(1'b0, 1'b1, act_log[k], k == act_log.size() - 1);
    end
endtask

// Serializer is known to accept the vector just finished
task automatic expect_vector();
    int i;
    for (i = 0; i < `PE_NUM; i++) begin
        exp_q.push_back(done_m[i]);
    end
endtask

task automatic drain_all(input logic random_fetch);
    int          cnt;
    logic [31:0] r;
    cnt = 0;
    while (exp_q.size() != 0) begin
        if (cnt >= DRAIN_TIMEOUT) begin
            fail_run("timed out waiting for s_valid words to drain the serializer");
        end else begin
            r = next_rand();
            tick(random_fetch ? r[3] : 1'b1, 1'b0, '0, 1'b0);
            cnt++;
        end
    end
    check_value("busy", 32'(busy), 32'h0);
endtask

// Extra fetch cycles prove that nothing more comes out
task automatic idle_fetches(input int n);
    int          k;
    logic [31:0] r;
    for (k = 0; k < n; k++) begin
        r = next_rand();
        tick(r[5], 1'b0, '0, 1'b0);
    end
endtask

//////////////////////////////////////////////////
// Tests
//////////////////////////////////////////////////

task automatic check_reset_state();
    @(negedge clk);
    check_value("s_valid", 32'(s_valid), 32'h0);
    check_value("busy", 32'(busy), 32'h0);
    check_value("overrun", 32'(overrun), 32'h0);
    check_value("s_out", s_out, 32'h0);
endtask

task automatic run_single_vector();
    overrun_cnt = 0;
    load_random_weights();
    stream_run(1 + int'(next_rand() % 32'd12), 1'b0);
    expect_vector();
    drain_all(1'b0);
    check_value("overrun pulses", 32'(overrun_cnt), 32'h0);
endtask

task automatic drain_irregular();
    stream_run(1 + int'(next_rand() % 32'd12), 1'b0);
    expect_vector();
    drain_all(1'b1);
    idle_fetches(8);
endtask

// Second run starts right after the first act_last
task automatic run_back_to_back();
    stream_run(1 + int'(next_rand() % 32'd12), 1'b0);
    expect_vector();
    stream_run(12 + int'(next_rand() % 32'd6), 1'b1);
    check_value("words left of first vector", 32'(exp_q.size()), 32'h0);
    expect_vector();
    drain_all(1'b0);
endtask

// Second vector lands on a full serializer and is lost
task automatic force_overrun();
    int cnt;
    overrun_cnt = 0;
    stream_run(1 + int'(next_rand() % 32'd8), 1'b0);
    expect_vector();
    stream_run(1 + int'(next_rand() % 32'd6), 1'b0);
    cnt = 0;
    while (overrun_cnt == 0) begin
        if (cnt >= OVERRUN_TIMEOUT) begin
            fail_run("timed out waiting for overrun after a load into a full serializer");
        end else begin
            tick(1'b0, 1'b0, '0, 1'b0);
            cnt++;
        end
    end
    drain_all(1'b0);
    idle_fetches(10);
    check_value("overrun pulses", 32'(overrun_cnt), 32'h1);
endtask

// Same activations again with one weight changed in between
task automatic rewrite_one_weight();
    int idx;
    load_random_weights();
    stream_run(2 + int'(next_rand() % 32'd10), 1'b0);
    expect_vector();
    drain_all(1'b0);
    idx = int'(next_rand() % 32'(`PE_NUM));
    write_weight(idx, ~weight_m[idx]);
    replay_run();
    expect_vector();
    drain_all(1'b0);
endtask

`endif

//--- verification/tb_pe_accel_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "pe_params.svh"

module tb_pe_accel_top;

    import pe_pkg::*;

    localparam int AW = `W_ADDR_WIDTH;

    // Cycle limits for every wait loop
    localparam int DRAIN_TIMEOUT   = 120;
    localparam int OVERRUN_TIMEOUT = 20;

    //////////////////////////////////////////////////
    // DUT signals
    //////////////////////////////////////////////////

    logic          clk = 1'b0;
    logic          rst_n;
    logic          w_wr;
    logic [AW-1:0] w_addr;
    data_t         w_data;
    data_t         act;
    logic          act_valid;
    logic          act_last;
    logic          fetch;
    acc_t          s_out;
    logic          s_valid;
    logic          busy;
    logic          overrun;

    //////////////////////////////////////////////////
    // Reference model state
    //////////////////////////////////////////////////

    // Weights as written, running and finished sums per element
    data_t       weight_m [`PE_NUM];
    acc_t        run_m    [`PE_NUM];
    acc_t        done_m   [`PE_NUM];

    // Words still expected on s_out, oldest first
    acc_t        exp_q [$];

    // Activations of the last random run, kept for replay
    data_t       act_log [$];

    int          overrun_cnt;
    logic [31:0] rng_state;

    // 100 ns period
    always #50 clk = ~clk;

    pe_accel_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .w_wr      (w_wr),
        .w_addr    (w_addr),
        .w_data    (w_data),
        .act       (act),
        .act_valid (act_valid),
        .act_last  (act_last),
        .fetch     (fetch),
        .s_out     (s_out),
        .s_valid   (s_valid),
        .busy      (busy),
        .overrun   (overrun)
    );

    // Stop the run at the first failure
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    `include "tb_pe_accel_tasks.svh"

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        rst_n       = 1'b0;
        w_wr        = 1'b0;
        w_addr      = '0;
        w_data      = '0;
        act         = '0;
        act_valid   = 1'b0;
        act_last    = 1'b0;
        fetch       = 1'b0;
        overrun_cnt = 0;
        rng_state   = 32'h4fcc;
        for (int i = 0; i < `PE_NUM; i++) begin
            weight_m[i] = '0;
            run_m[i]    = '0;
            done_m[i]   = '0;
        end

        // Reset held for 5 cycles, released on a falling edge
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_reset_state();
        run_single_vector();
        drain_irregular();
        run_back_to_back();
        force_overrun();
        rewrite_one_weight();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/pe_accel_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "pe_params.svh"

module pe_accel_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // Weight write port
    input  logic                     w_wr,
    input  logic [`W_ADDR_WIDTH-1:0] w_addr,
    input  pe_pkg::data_t            w_data,
    // Activation stream
    input  pe_pkg::data_t            act,
    input  logic                     act_valid,
    input  logic                     act_last,
    // Result readout
    input  logic                     fetch,
    output pe_pkg::acc_t             s_out,
    output logic                     s_valid,
    output logic                     busy,
    output logic                     overrun
);

    import pe_pkg::*;

    //////////////////////////////////////////////////
    // Array to serializer
    //////////////////////////////////////////////////

    // Complete sums of the last finished stream
    acc_vec_t results;

    // One-cycle strobe marking a fresh vector
    logic     res_valid;

    //////////////////////////////////////////////////
    // MAC row
    //////////////////////////////////////////////////

    pe_array pe_array_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .w_wr      (w_wr),
        .w_addr    (w_addr),
        .w_data    (w_data),
        .act       (act),
        .act_valid (act_valid),
        .act_last  (act_last),
        .results   (results),
        .res_valid (res_valid)
    );

    //////////////////////////////////////////////////
    // Result serializer
    //////////////////////////////////////////////////

    // Strobe drives load directly
    // A vector arriving during a drain is dropped
    piso piso_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .p_in    (results),
        .load    (res_valid),
        .fetch   (fetch),
        .s_out   (s_out),
        .s_valid (s_valid),
        .busy    (busy),
        .overrun (overrun)
    );

endmodule

`default_nettype wire

//--- verilog/piso.sv
`timescale 1ns/100ps
`default_nettype none

`include "pe_params.svh"

module piso (
    input  logic              clk,
    input  logic              rst_n,
    // Parallel side
    input  pe_pkg::acc_vec_t  p_in,
    input  logic              load,
    // Serial side
    input  logic              fetch,
    output pe_pkg::acc_t      s_out,
    output logic              s_valid,
    // Status
    output logic              busy,
    output logic              overrun
);

    import pe_pkg::*;

    // Counter must reach PE_NUM itself
    localparam int CNT_W = $clog2(`PE_NUM + 1);

    // Words still waiting to be fetched
    acc_vec_t         shreg;
    logic [CNT_W-1:0] words_left;

    // Per-cycle decisions
    logic             fetch_ok;
    logic [CNT_W-1:0] words_after;
    logic             load_ok;
    logic             load_drop;

    // Output registers
    acc_t             s_out_q;
    logic             s_valid_q;
    logic             overrun_q;

    //////////////////////////////////////////////////
    // Accept logic
    //////////////////////////////////////////////////

    // Fetch on an empty register does nothing
    assign fetch_ok    = fetch && (words_left != '0);
    assign words_after = words_left - {{(CNT_W-1){1'b0}}, fetch_ok};

    // Load only into a register that this cycle's fetch empties
    assign load_ok   = load && (words_after == '0);
    assign load_drop = load && (words_after != '0);

    //////////////////////////////////////////////////
    // Shift register
    //////////////////////////////////////////////////

    // Word 0 always sits in the lowest slice
    always_ff @(posedge clk) begin
        if (load_ok) begin
            shreg <= p_in;
        end else if (fetch_ok) begin
            shreg <= {acc_t'(0), shreg[`PE_NUM-1:1]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            words_left <= '0;
        end else if (load_ok) begin
            words_left <= CNT_W'(`PE_NUM);
        end else begin
            words_left <= words_after;
        end
    end

    //////////////////////////////////////////////////
    // Serial output and status
    //////////////////////////////////////////////////

    // s_out keeps its last word while s_valid is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_out_q   <= '0;
            s_valid_q <= 1'b0;
            overrun_q <= 1'b0;
        end else begin
            s_valid_q <= fetch_ok;
            overrun_q <= load_drop;
            if (fetch_ok) begin
                s_out_q <= shreg[0];
            end
        end
    end

    assign s_out   = s_out_q;
    assign s_valid = s_valid_q;
    assign overrun = overrun_q;

    // Busy while any word is left
    assign busy = (words_left != '0);

endmodule

`default_nettype wire

//--- verilog/pe_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "pe_params.svh"

module pe_array (
    input  logic                     clk,
    input  logic                     rst_n,
    // Weight write port
    input  logic                     w_wr,
    input  logic [`W_ADDR_WIDTH-1:0] w_addr,
    input  pe_pkg::data_t            w_data,
    // Broadcast activation stream
    input  pe_pkg::data_t            act,
    input  logic                     act_valid,
    input  logic                     act_last,
    // Result vector and its strobe
    output pe_pkg::acc_vec_t         results,
    output logic                     res_valid
);

    import pe_pkg::*;

    // One write enable per element
    logic [`PE_NUM-1:0] w_en;

    // Sums coming out of each element
    acc_t pe_sum [`PE_NUM];

    // Registered end-of-stream strobe
    logic res_valid_q;

    //////////////////////////////////////////////////
    // Weight write decode
    //////////////////////////////////////////////////

    // At most one element is written per cycle
    always_comb begin
        w_en = '0;
        if (w_wr) begin
            w_en[w_addr] = 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Processing element row
    //////////////////////////////////////////////////

    genvar i;
    generate
        for (i = 0; i < `PE_NUM; i++) begin : g_pe
            // Same activation goes to every element
            mac_pe mac_pe_i (
                .clk       (clk),
                .rst_n     (rst_n),
                .w_en      (w_en[i]),
                .w_data    (w_data),
                .act       (act),
                .act_valid (act_valid),
                .act_last  (act_last),
                .acc       (pe_sum[i])
            );

            // Element i lands in slice i
            assign results[i] = pe_sum[i];
        end
    endgenerate

    //////////////////////////////////////////////////
    // Result strobe
    //////////////////////////////////////////////////

    // High in the cycle after the last activation
    // Lines up with the held sums in every element
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= act_valid & act_last;
        end
    end

    assign res_valid = res_valid_q;

endmodule

`default_nettype wire

//--- verilog/mac_pe.sv
`timescale 1ns/100ps
`default_nettype none

module mac_pe (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           w_en,
    input  pe_pkg::data_t  w_data,
    input  pe_pkg::data_t  act,
    input  logic           act_valid,
    input  logic           act_last,
    output pe_pkg::acc_t   acc
);

    import pe_pkg::*;

    // Stored weight of this element
    data_t weight;

    // Running sum of the current stream
    acc_t acc_run;

    // Final sum of the previous stream
    acc_t acc_hold;

    // Product and next running sum
    acc_t product;
    acc_t sum_next;

    //////////////////////////////////////////////////
    // Weight register
    //////////////////////////////////////////////////

    // New weight applies from the next activation on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight <= '0;
        end else if (w_en) begin
            weight <= w_data;
        end
    end

    //////////////////////////////////////////////////
    // Multiply-accumulate
    //////////////////////////////////////////////////

    // Sign-extend both operands to full width first
    // A 16x16 signed product always fits in 32 bits
    assign product  = acc_t'(weight) * acc_t'(act);
    assign sum_next = acc_run + product;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_run  <= '0;
            acc_hold <= '0;
        end else if (act_valid) begin
            if (act_last) begin
                // Hand off the complete sum and restart
                acc_hold <= sum_next;
                acc_run  <= '0;
            end else begin
                acc_run  <= sum_next;
            end
        end
    end

    // Held sum stays stable while the next stream accumulates
    assign acc = acc_hold;

endmodule

`default_nettype wire

//--- verilog/pe_pkg.sv
`default_nettype none

`include "pe_params.svh"

package pe_pkg;

    //////////////////////////////////////////////////
    // Datapath types
    //////////////////////////////////////////////////

    // Signed activation or weight
    typedef logic signed [`DATA_WIDTH-1:0] data_t;

    // Signed accumulator holding the full product width
    // Sums wrap on overflow
    typedef logic signed [2*`DATA_WIDTH-1:0] acc_t;

    // One sum per element
    // Element 0 occupies the lowest slice
    typedef acc_t [`PE_NUM-1:0] acc_vec_t;

endpackage

`default_nettype wire

//--- verilog/pe_params.svh
`ifndef PE_PARAMS_SVH
`define PE_PARAMS_SVH

// Shared sizing of the MAC row and result serializer

// Number of processing elements in the row
`define PE_NUM 8

// Activation and weight width
// Accumulators run at twice this width
`define DATA_WIDTH 16

// Weight write address
// Must be wide enough to index every element
`define W_ADDR_WIDTH 3

`endif
